/* vec_pkg.sv */
// vector execution backend package
// sizes, operation encodings, lane views and the request and result records

package vec_pkg;

        localparam int unsigned id_w         = 4;
        localparam int unsigned vreg_addr_w  = 5;
        localparam int unsigned data_w       = 32;
        localparam int unsigned strb_w       = data_w / 8;
        localparam int unsigned lane_cnt_max = 4;

        typedef enum logic {
                UNIT_ALU = 1'b0,
                UNIT_MUL = 1'b1
        } exec_unit_e;

        typedef enum logic [1:0] {
                ALU_ADD     = 2'd0,
                ALU_SUB     = 2'd1,
                ALU_CMP_EQ  = 2'd2,
                ALU_CMP_LTU = 2'd3
        } alu_op_e;

        typedef enum logic [1:0] {
                EEW_8  = 2'd0,
                EEW_16 = 2'd1,
                EEW_32 = 2'd2
        } eew_e;

        // one operand word seen as bytes or as halfwords
        typedef union packed {
                logic [3:0][7:0]  b;
                logic [1:0][15:0] h;
        } lane_word_u;

        typedef struct packed {
                logic [id_w-1:0]         id;
                exec_unit_e              unit;
                alu_op_e                 op;
                eew_e                    eew;
                logic [vreg_addr_w-1:0]  vaddr;
                lane_word_u              op1;
                lane_word_u              op2;
                logic [lane_cnt_max-1:0] mask;
        } exec_req_t;

        typedef struct packed {
                logic [id_w-1:0]        id;
                logic [vreg_addr_w-1:0] vaddr;
                eew_e                   eew;
                logic [data_w-1:0]      data;
                logic [strb_w-1:0]      strb;
                logic                   cmp;
        } wb_res_t;

        // spread the per-lane mask over the bytes of each lane
        function automatic logic [strb_w-1:0] lane_strb(eew_e eew, logic [lane_cnt_max-1:0] mask);
                logic [strb_w-1:0] strb;
                strb = '0;
                unique case (eew)
                        EEW_8:   strb = mask;
                        EEW_16:  strb = {{2{mask[1]}}, {2{mask[0]}}};
                        EEW_32:  strb = {4{mask[0]}};
                        default: strb = '0;
                endcase
                return strb;
        endfunction

        // zero every data byte whose strobe bit is clear
        function automatic logic [data_w-1:0] strb_data(logic [data_w-1:0] data,
                                                        logic [strb_w-1:0] strb);
                logic [data_w-1:0] res;
                for (int i = 0; i < strb_w; i++) begin
                        res[8*i +: 8] = strb[i] ? data[8*i +: 8] : 8'h00;
                end
                return res;
        endfunction

endpackage

/* vec_alu.sv */
// vector ALU
// lane-wise add, subtract and unsigned compare with one output register

`timescale 1ns/1ps

module vec_alu (
        input  logic                clk_i,
        input  logic                arst_n_i,

        input  logic                in_valid_i,
        output logic                in_ready_o,
        input  vec_pkg::exec_req_t  in_req_i,

        output logic                out_valid_o,
        input  logic                out_ready_i,
        output vec_pkg::wb_res_t    out_res_o
);

        logic             is_sub;
        logic [3:0][7:0]  res_b;
        logic [1:0][15:0] res_h;
        logic [31:0]      res_w;
        logic [3:0]       eq_b, ltu_b;
        logic [1:0]       eq_h, ltu_h;
        logic             eq_w, ltu_w;

        logic [vec_pkg::data_w-1:0]       arith;
        logic [vec_pkg::lane_cnt_max-1:0] eq_v, ltu_v;
        logic [vec_pkg::strb_w-1:0]       strb;
        vec_pkg::wb_res_t                 res_d;

        logic             out_valid_q;
        vec_pkg::wb_res_t out_res_q;

        assign is_sub = in_req_i.op == vec_pkg::ALU_SUB;

        // every lane width is computed, eew picks one below
        always_comb begin
                for (int k = 0; k < 4; k++) begin
                        res_b[k] = is_sub ? in_req_i.op1.b[k] - in_req_i.op2.b[k]
                                          : in_req_i.op1.b[k] + in_req_i.op2.b[k];
                        eq_b[k]  = in_req_i.op1.b[k] == in_req_i.op2.b[k];
                        ltu_b[k] = in_req_i.op1.b[k] <  in_req_i.op2.b[k];
                end
                for (int k = 0; k < 2; k++) begin
                        res_h[k] = is_sub ? in_req_i.op1.h[k] - in_req_i.op2.h[k]
                                          : in_req_i.op1.h[k] + in_req_i.op2.h[k];
                        eq_h[k]  = in_req_i.op1.h[k] == in_req_i.op2.h[k];
                        ltu_h[k] = in_req_i.op1.h[k] <  in_req_i.op2.h[k];
                end
                res_w = is_sub ? in_req_i.op1 - in_req_i.op2 : in_req_i.op1 + in_req_i.op2;
                eq_w  = in_req_i.op1 == in_req_i.op2;
                ltu_w = in_req_i.op1 <  in_req_i.op2;
        end

        always_comb begin
                arith = '0;
                eq_v  = '0;
                ltu_v = '0;
                unique case (in_req_i.eew)
                        vec_pkg::EEW_8: begin
                                arith = res_b;
                                eq_v  = eq_b;
                                ltu_v = ltu_b;
                        end
                        vec_pkg::EEW_16: begin
                                arith = res_h;
                                eq_v  = {2'b00, eq_h};
                                ltu_v = {2'b00, ltu_h};
                        end
                        vec_pkg::EEW_32: begin
                                arith = res_w;
                                eq_v  = {3'b000, eq_w};
                                ltu_v = {3'b000, ltu_w};
                        end
                        default: ;
                endcase
        end

        assign strb = vec_pkg::lane_strb(in_req_i.eew, in_req_i.mask);

        always_comb begin
                res_d.id    = in_req_i.id;
                res_d.vaddr = in_req_i.vaddr;
                res_d.eew   = in_req_i.eew;
                res_d.cmp   = 1'b0;
                res_d.strb  = strb;
                res_d.data  = vec_pkg::strb_data(arith, strb);
                if (in_req_i.op == vec_pkg::ALU_CMP_EQ || in_req_i.op == vec_pkg::ALU_CMP_LTU) begin
                        res_d.cmp  = 1'b1;
                        res_d.strb = 4'b0001;           // mask bits land in byte 0
                        res_d.data = '0;
                        res_d.data[vec_pkg::lane_cnt_max-1:0] =
                                (in_req_i.op == vec_pkg::ALU_CMP_EQ ? eq_v : ltu_v) & in_req_i.mask;
                end
        end

        assign in_ready_o = ~out_valid_q | out_ready_i;

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        out_valid_q <= 1'b0;
                end else if (in_ready_o) begin
                        out_valid_q <= in_valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_valid_i && in_ready_o) begin
                        out_res_q <= res_d;
                end
        end

        assign out_valid_o = out_valid_q;
        assign out_res_o   = out_res_q;

        a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_res_o));

endmodule

/* vec_mul.sv */
// vector multiplier
// two-stage lane-wise multiply keeping the low half of each lane product

`timescale 1ns/1ps

module vec_mul (
        input  logic                clk_i,
        input  logic                arst_n_i,

        input  logic                in_valid_i,
        output logic                in_ready_o,
        input  vec_pkg::exec_req_t  in_req_i,

        output logic                out_valid_o,
        input  logic                out_ready_i,
        output vec_pkg::wb_res_t    out_res_o
);

        // stage one record with the full lane products
        typedef struct packed {
                logic [vec_pkg::id_w-1:0]         id;
                logic [vec_pkg::vreg_addr_w-1:0]  vaddr;
                vec_pkg::eew_e                    eew;
                logic [vec_pkg::lane_cnt_max-1:0] mask;
                logic [2*vec_pkg::data_w-1:0]     prod;
        } mul_s1_t;

        logic    advance;
        mul_s1_t s1_d, s1_q;
        logic    s1_valid_q;

        logic [vec_pkg::data_w-1:0] trunc;
        logic [vec_pkg::strb_w-1:0] strb;
        vec_pkg::wb_res_t           res_d, s2_q;
        logic                       s2_valid_q;

        // full output stage that is not taken freezes both stages
        assign advance    = ~s2_valid_q | out_ready_i;
        assign in_ready_o = advance;

        always_comb begin
                s1_d.id    = in_req_i.id;
                s1_d.vaddr = in_req_i.vaddr;
                s1_d.eew   = in_req_i.eew;
                s1_d.mask  = in_req_i.mask;
                s1_d.prod  = '0;
                unique case (in_req_i.eew)
                        vec_pkg::EEW_8: begin
                                for (int k = 0; k < 4; k++) begin
                                        s1_d.prod[16*k +: 16] =
                                                16'(in_req_i.op1.b[k]) * 16'(in_req_i.op2.b[k]);
                                end
                        end
                        vec_pkg::EEW_16: begin
                                for (int k = 0; k < 2; k++) begin
                                        s1_d.prod[32*k +: 32] =
                                                32'(in_req_i.op1.h[k]) * 32'(in_req_i.op2.h[k]);
                                end
                        end
                        vec_pkg::EEW_32: s1_d.prod = 64'(in_req_i.op1) * 64'(in_req_i.op2);
                        default: ;
                endcase
        end

        // low half of each product
        always_comb begin
                trunc = '0;
                unique case (s1_q.eew)
                        vec_pkg::EEW_8: begin
                                for (int k = 0; k < 4; k++) begin
                                        trunc[8*k +: 8] = s1_q.prod[16*k +: 8];
                                end
                        end
                        vec_pkg::EEW_16: begin
                                for (int k = 0; k < 2; k++) begin
                                        trunc[16*k +: 16] = s1_q.prod[32*k +: 16];
                                end
                        end
                        vec_pkg::EEW_32: trunc = s1_q.prod[vec_pkg::data_w-1:0];
                        default: ;
                endcase
        end

        assign strb = vec_pkg::lane_strb(s1_q.eew, s1_q.mask);

        always_comb begin
                res_d.id    = s1_q.id;
                res_d.vaddr = s1_q.vaddr;
                res_d.eew   = s1_q.eew;
                res_d.data  = vec_pkg::strb_data(trunc, strb);
                res_d.strb  = strb;
                res_d.cmp   = 1'b0;
        end

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        s1_valid_q <= 1'b0;
                        s2_valid_q <= 1'b0;
                end else if (advance) begin
                        s1_valid_q <= in_valid_i;
                        s2_valid_q <= s1_valid_q;
                end
        end

        always_ff @(posedge clk_i) begin
                if (advance) begin
                        s1_q <= s1_d;
                        s2_q <= res_d;
                end
        end

        assign out_valid_o = s2_valid_q;
        assign out_res_o   = s2_q;

        a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_res_o));

endmodule

/* wb_arbiter.sv */
// writeback arbiter
// round-robin merge of the ALU and MUL result streams onto one port

`timescale 1ns/1ps

module wb_arbiter (
        input  logic              clk_i,
        input  logic              arst_n_i,

        input  logic              alu_valid_i,
        output logic              alu_ready_o,
        input  vec_pkg::wb_res_t  alu_res_i,

        input  logic              mul_valid_i,
        output logic              mul_ready_o,
        input  vec_pkg::wb_res_t  mul_res_i,

        output logic              wb_valid_o,
        input  logic              wb_ready_i,
        output vec_pkg::wb_res_t  wb_o
);

        logic [1:0] fresh;              // bit 0 alu, bit 1 mul
        logic [1:0] grant;
        logic [1:0] held_q;             // grant locked by a stalled transfer
        logic       last_mul_q;

        always_comb begin
                fresh = 2'b00;
                if (alu_valid_i && mul_valid_i) begin
                        fresh = last_mul_q ? 2'b01 : 2'b10;
                end else if (alu_valid_i) begin
                        fresh = 2'b01;
                end else if (mul_valid_i) begin
                        fresh = 2'b10;
                end
        end

        assign grant = (held_q != 2'b00) ? held_q : fresh;

        assign wb_valid_o  = (grant[0] & alu_valid_i) | (grant[1] & mul_valid_i);
        assign wb_o        = grant[1] ? mul_res_i : alu_res_i;
        assign alu_ready_o = grant[0] & wb_ready_i;
        assign mul_ready_o = grant[1] & wb_ready_i;

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        held_q     <= 2'b00;
                        last_mul_q <= 1'b1;     // alu wins the first tie
                end else begin
                        held_q <= (wb_valid_o && !wb_ready_i) ? grant : 2'b00;
                        if (wb_valid_o && wb_ready_i) begin
                                last_mul_q <= grant[1];
                        end
                end
        end

        // a held grant also needs its unit to keep valid up
        a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                $onehot0(grant) && (grant & {mul_valid_i, alu_valid_i}) == grant);

        a_grant_locked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                wb_valid_o && !wb_ready_i |=> grant == $past(grant));

endmodule

/* vec_exec_top.sv */
// vector execution backend top
// steers requests to the ALU or the multiplier and arbitrates their writeback

`timescale 1ns/1ps

module vec_exec_top (
        input  logic                clk_i,
        input  logic                arst_n_i,

        input  logic                req_valid_i,
        output logic                req_ready_o,
        input  vec_pkg::exec_req_t  req_i,

        output logic                wb_valid_o,
        input  logic                wb_ready_i,
        output vec_pkg::wb_res_t    wb_o
);

        logic             to_mul;
        logic             alu_in_valid, alu_in_ready;
        logic             mul_in_valid, mul_in_ready;

        logic             alu_out_valid, alu_out_ready;
        vec_pkg::wb_res_t alu_out_res;
        logic             mul_out_valid, mul_out_ready;
        vec_pkg::wb_res_t mul_out_res;

        assign to_mul       = req_i.unit == vec_pkg::UNIT_MUL;
        assign alu_in_valid = req_valid_i & ~to_mul;
        assign mul_in_valid = req_valid_i &  to_mul;
        assign req_ready_o  = to_mul ? mul_in_ready : alu_in_ready;

        vec_alu u_alu (
                .clk_i       ( clk_i         ),
                .arst_n_i    ( arst_n_i      ),
                .in_valid_i  ( alu_in_valid  ),
                .in_ready_o  ( alu_in_ready  ),
                .in_req_i    ( req_i         ),
                .out_valid_o ( alu_out_valid ),
                .out_ready_i ( alu_out_ready ),
                .out_res_o   ( alu_out_res   )
        );

        vec_mul u_mul (
                .clk_i       ( clk_i         ),
                .arst_n_i    ( arst_n_i      ),
                .in_valid_i  ( mul_in_valid  ),
                .in_ready_o  ( mul_in_ready  ),
                .in_req_i    ( req_i         ),
                .out_valid_o ( mul_out_valid ),
                .out_ready_i ( mul_out_ready ),
                .out_res_o   ( mul_out_res   )
        );

        wb_arbiter u_arb (
                .clk_i       ( clk_i         ),
                .arst_n_i    ( arst_n_i      ),
                .alu_valid_i ( alu_out_valid ),
                .alu_ready_o ( alu_out_ready ),
                .alu_res_i   ( alu_out_res   ),
                .mul_valid_i ( mul_out_valid ),
                .mul_ready_o ( mul_out_ready ),
                .mul_res_i   ( mul_out_res   ),
                .wb_valid_o  ( wb_valid_o    ),
                .wb_ready_i  ( wb_ready_i    ),
                .wb_o        ( wb_o          )
        );

endmodule

/* tb_vec_exec_table.svh */
// stimulus and expected results for the vector execution testbench
// columns: unit, op, eew, vaddr, then op1, op2, mask, expected data, strobe, cmp

// add and subtract, carries stay inside each lane
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_ADD, vec_pkg::EEW_8, 5'd1,
          32'h01ff7f80, 32'h01010180, 4'b1111, 32'h02008000, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_SUB, vec_pkg::EEW_8, 5'd2,
          32'h001005ff, 32'h01010601, 4'b1111, 32'hff0ffffe, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_ADD, vec_pkg::EEW_16, 5'd3,
          32'h8001ffff, 32'h80000002, 4'b0011, 32'h00010001, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_SUB, vec_pkg::EEW_16, 5'd4,
          32'h00001234, 32'h00010235, 4'b0011, 32'hffff0fff, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_ADD, vec_pkg::EEW_32, 5'd5,
          32'hffffffff, 32'h00000002, 4'b0001, 32'h00000001, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_SUB, vec_pkg::EEW_32, 5'd6,
          32'h00000000, 32'h00000001, 4'b1111, 32'hffffffff, 4'b1111, 1'b0);
// compares, one bit per lane in byte 0
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_CMP_EQ, vec_pkg::EEW_8, 5'd7,
          32'h11223344, 32'h11003344, 4'b1111, 32'h0000000b, 4'b0001, 1'b1);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_CMP_LTU, vec_pkg::EEW_8, 5'd8,
          32'h017fff00, 32'h0280ff01, 4'b0111, 32'h00000005, 4'b0001, 1'b1);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_CMP_LTU, vec_pkg::EEW_16, 5'd9,
          32'h0001ffff, 32'h8000fffe, 4'b1111, 32'h00000002, 4'b0001, 1'b1);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_CMP_EQ, vec_pkg::EEW_32, 5'd10,
          32'hdeadbeef, 32'hdeadbeef, 4'b0001, 32'h00000001, 4'b0001, 1'b1);
// back-to-back multiplies, low half of each product
add_entry(vec_pkg::UNIT_MUL, vec_pkg::ALU_ADD, vec_pkg::EEW_8, 5'd11,
          32'h10ff0380, 32'h10ff0502, 4'b1111, 32'h00010f00, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_MUL, vec_pkg::ALU_ADD, vec_pkg::EEW_16, 5'd12,
          32'h01001234, 32'h01000010, 4'b0011, 32'h00002340, 4'b1111, 1'b0);
add_entry(vec_pkg::UNIT_MUL, vec_pkg::ALU_ADD, vec_pkg::EEW_32, 5'd13,
          32'h00010001, 32'h00010001, 4'b0001, 32'h00020001, 4'b1111, 1'b0);
// masked lanes, mixed units
add_entry(vec_pkg::UNIT_MUL, vec_pkg::ALU_ADD, vec_pkg::EEW_8, 5'd14,
          32'h02030405, 32'h03030303, 4'b0101, 32'h0009000f, 4'b0101, 1'b0);
add_entry(vec_pkg::UNIT_ALU, vec_pkg::ALU_ADD, vec_pkg::EEW_16, 5'd15,
          32'h11112222, 32'h01010202, 4'b1110, 32'h12120000, 4'b1100, 1'b0);
add_entry(vec_pkg::UNIT_MUL, vec_pkg::ALU_ADD, vec_pkg::EEW_32, 5'd16,
          32'h00000007, 32'h00000006, 4'b1110, 32'h00000000, 4'b0000, 1'b0);

/* tb_vec_exec.sv */
// testbench for the vector execution backend
// table-driven requests under random writeback back-pressure with an id scoreboard

`timescale 1ns/1ps

module tb_vec_exec;

        localparam int half_period    = 50;
        localparam int sample_dly     = 40;     // 10 ns before the rising edge
        localparam int reset_cycles   = 4;
        localparam int tbl_size       = 16;
        localparam int timeout_cycles = tbl_size * 12 + 50;

        typedef struct packed {
                vec_pkg::exec_unit_e                unit;
                vec_pkg::alu_op_e                   op;
                vec_pkg::eew_e                      eew;
                logic [vec_pkg::vreg_addr_w-1:0]    vaddr;
                logic [vec_pkg::data_w-1:0]         op1;
                logic [vec_pkg::data_w-1:0]         op2;
                logic [vec_pkg::lane_cnt_max-1:0]   mask;
                logic [vec_pkg::data_w-1:0]         exp_data;
                logic [vec_pkg::strb_w-1:0]         exp_strb;
                logic                               exp_cmp;
        } vec_case_t;

        logic               clk_i;
        logic               arst_n_i;
        logic               req_valid_i;
        logic               req_ready_o;
        vec_pkg::exec_req_t req_i;
        logic               wb_valid_o;
        logic               wb_ready_i;
        vec_pkg::wb_res_t   wb_o;

        vec_case_t          tbl [tbl_size];
        int                 tbl_cnt;
        int                 next_idx;
        int                 seed;
        int unsigned        rnd;
        int                 cycle_cnt = 0;
        logic [tbl_size-1:0] seen;
        logic [tbl_size-1:0] issued;
        logic               req_acc;
        logic               stall_prev;
        vec_pkg::wb_res_t   wb_prev;

        vec_exec_top uut (
                .clk_i       ( clk_i       ),
                .arst_n_i    ( arst_n_i    ),
                .req_valid_i ( req_valid_i ),
                .req_ready_o ( req_ready_o ),
                .req_i       ( req_i       ),
                .wb_valid_o  ( wb_valid_o  ),
                .wb_ready_i  ( wb_ready_i  ),
                .wb_o        ( wb_o        )
        );

        always #(half_period) clk_i = ~clk_i;

        always @(posedge clk_i) begin
                cycle_cnt = cycle_cnt + 1;
                if (cycle_cnt > timeout_cycles) begin
                        $display("RESULT: FAIL");
                        $fatal(1, "timeout, not all writebacks arrived within %0d cycles",
                               timeout_cycles);
                end
        end

        task automatic check_value(input string name, input logic [63:0] act,
                                   input logic [63:0] exp);
                if (act !== exp) begin
                        $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
                        $display("RESULT: FAIL");
                        $fatal(1, "value check failed");
                end
        endtask

        task automatic add_entry(input vec_pkg::exec_unit_e unit, input vec_pkg::alu_op_e op,
                                 input vec_pkg::eew_e eew, input logic [4:0] vaddr,
                                 input logic [31:0] op1, input logic [31:0] op2,
                                 input logic [3:0] mask, input logic [31:0] exp_data,
                                 input logic [3:0] exp_strb, input logic exp_cmp);
                vec_case_t c;
                c.unit     = unit;
                c.op       = op;
                c.eew      = eew;
                c.vaddr    = vaddr;
                c.op1      = op1;
                c.op2      = op2;
                c.mask     = mask;
                c.exp_data = exp_data;
                c.exp_strb = exp_strb;
                c.exp_cmp  = exp_cmp;
                tbl[tbl_cnt[3:0]] = c;
                tbl_cnt = tbl_cnt + 1;
        endtask

        task automatic load_table();
                tbl_cnt = 0;
                `include "tb_vec_exec_table.svh"
        endtask

        function automatic vec_pkg::exec_req_t build_req(input logic [3:0] idx);
                vec_pkg::exec_req_t r;
                r.id    = idx;          // id is the table index
                r.unit  = tbl[idx].unit;
                r.op    = tbl[idx].op;
                r.eew   = tbl[idx].eew;
                r.vaddr = tbl[idx].vaddr;
                r.op1   = tbl[idx].op1;
                r.op2   = tbl[idx].op2;
                r.mask  = tbl[idx].mask;
                return r;
        endfunction

        task automatic score_writeback(input vec_pkg::wb_res_t res);
                vec_case_t want;
                want = tbl[res.id];
                if (!issued[res.id]) begin
                        $display("RESULT: FAIL");
                        $fatal(1, "writeback for id %0d that was never issued", res.id);
                end
                if (seen[res.id]) begin
                        $display("RESULT: FAIL");
                        $fatal(1, "id %0d was written back twice", res.id);
                end
                check_value("wb_o.vaddr", 64'(res.vaddr), 64'(want.vaddr));
                check_value("wb_o.eew", 64'(res.eew), 64'(want.eew));
                check_value("wb_o.data", 64'(res.data), 64'(want.exp_data));
                check_value("wb_o.strb", 64'(res.strb), 64'(want.exp_strb));
                check_value("wb_o.cmp", 64'(res.cmp), 64'(want.exp_cmp));
                seen[res.id] = 1'b1;
        endtask

        initial begin
                clk_i       = 1'b0;
                arst_n_i    = 1'b0;
                req_valid_i = 1'b0;
                req_i       = '0;
                wb_ready_i  = 1'b0;
                seed        = 20;
                seen        = '0;
                issued      = '0;
                next_idx    = 0;
                req_acc     = 1'b0;
                stall_prev  = 1'b0;
                wb_prev     = '0;
                load_table();

                repeat (reset_cycles) @(posedge clk_i);
                @(negedge clk_i);
                arst_n_i = 1'b1;
                #(sample_dly);
                check_value("wb_valid_o", 64'(wb_valid_o), 64'(1'b0));
                check_value("req_ready_o", 64'(req_ready_o), 64'(1'b1));

                while (seen != '1) begin
                        @(negedge clk_i);
                        if (req_acc) begin
                                next_idx = next_idx + 1;
                        end
                        rnd = $random(seed);
                        wb_ready_i = (rnd % 3) != 0;    // high about two thirds of the time
                        if (next_idx < tbl_cnt) begin
                                req_valid_i = 1'b1;
                                req_i       = build_req(next_idx[3:0]);
                        end else begin
                                req_valid_i = 1'b0;
                                req_i       = '0;
                        end

                        #(sample_dly);
                        // multiplier takes a request unless an ALU result holds the port
                        if (req_valid_i && req_i.unit == vec_pkg::UNIT_MUL && wb_ready_i &&
                            !(wb_valid_o && tbl[wb_o.id].unit == vec_pkg::UNIT_ALU)) begin
                                check_value("req_ready_o", 64'(req_ready_o), 64'(1'b1));
                        end
                        req_acc = req_valid_i && req_ready_o;
                        if (req_acc) begin
                                issued[next_idx[3:0]] = 1'b1;
                        end
                        if (stall_prev) begin
                                check_value("wb_valid_o", 64'(wb_valid_o), 64'(1'b1));
                                check_value("wb_o", 64'(wb_o), 64'(wb_prev));
                        end
                        if (wb_valid_o && wb_ready_i) begin
                                score_writeback(wb_o);
                        end
                        stall_prev = wb_valid_o && !wb_ready_i;
                        wb_prev    = wb_o;
                end

                // nothing may leave once every id is back
                repeat (3) begin
                        @(negedge clk_i);
                        req_valid_i = 1'b0;
                        wb_ready_i  = 1'b1;
                        #(sample_dly);
                        check_value("wb_valid_o", 64'(wb_valid_o), 64'(1'b0));
                end

                $display("RESULT: PASS");
                $finish;
        end

endmodule

/* vlog.f */
+incdir+.
vec_pkg.sv
vec_alu.sv
vec_mul.sv
wb_arbiter.sv
vec_exec_top.sv
tb_vec_exec.sv

/* Makefile */
# Verilator build for the vector execution backend

VERILATOR ?= verilator
TOP       := tb_vec_exec
FILELIST  := vlog.f
BUILD_DIR := obj_dir
VFLAGS    := --timing --assert --timescale 1ns/1ps
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives the binary a failing exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
